// ==== design/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Datapath and address width
`define EX_XLEN 32

// Valid instructions dropped after a redirect
`define EX_FLUSH_SLOTS 2

`define EX_STATUS_RESET 32'h0000FA01
`define EX_EBASE_RESET  32'h80001000
`define EX_EXC_OFFSET   32'h00000180 // General exception entry

`endif

// ==== design/ex_cp0_pkg.sv ====
`default_nettype none

package ex_cp0_pkg;

    typedef enum logic [4:0] {
        SYS = 5'd8,
        BP  = 5'd9,
        RI  = 5'd10,
        OV  = 5'd12
    } exc_code_t;

    typedef enum logic [4:0] {
        STATUS = 5'd12,
        CAUSE  = 5'd13,
        EPC    = 5'd14,
        EBASE  = 5'd15
    } cp0_idx_t;

    localparam int STATUS_EXL   = 1;
    localparam int CAUSE_IP_HI  = 15; // IP7..IP2
    localparam int CAUSE_IP_LO  = 10;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_EXC_LO = 2;

endpackage

`default_nettype wire

// ==== design/ex_isa_pkg.sv ====
`default_nettype none

`include "ex_config.svh"

package ex_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J     = 6'h02, OP_JAL   = 6'h03, OP_BEQ  = 6'h04,
        OP_BNE     = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07, OP_ADDI = 6'h08,
        OP_ADDIU   = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c,
        OP_ORI     = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f, OP_COP0 = 6'h10
    } opcode_t;

    typedef enum logic [5:0] {
        F_SLL     = 6'h00, F_SRL  = 6'h02, F_SRA  = 6'h03, F_SLLV = 6'h04,
        F_SRLV    = 6'h06, F_SRAV = 6'h07, F_JR   = 6'h08, F_JALR = 6'h09,
        F_SYSCALL = 6'h0c, F_BREAK = 6'h0d, F_ADD = 6'h20, F_ADDU = 6'h21,
        F_SUB     = 6'h22, F_SUBU = 6'h23, F_AND  = 6'h24, F_OR   = 6'h25,
        F_XOR     = 6'h26, F_NOR  = 6'h27, F_SLT  = 6'h2a, F_SLTU = 6'h2b
    } funct_t;

    // COP0 rs field and ERET function
    localparam logic [4:0] RS_MF      = 5'b00000;
    localparam logic [4:0] RS_MT      = 5'b00100;
    localparam logic [5:0] ERET_FUNCT = 6'h18;

    typedef enum logic [3:0] {
        ALU, BRANCH, JUMP, JUMP_REG, MFC0, MTC0, ERET, SYSCALL, BREAK, RESERVED
    } instr_class_t;

    // The I suffixed ops take the immediate on the B side
    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_SLT, ALU_SLTU,
        ALU_ADDI, ALU_ADDIU, ALU_ANDI, ALU_ORI, ALU_XORI, ALU_SLTI, ALU_SLTIU, ALU_LUI
    } alu_op_t;

    typedef struct packed {
        logic                reg_write;
        logic [`EX_XLEN-1:0] result;
    } wb_t;

    typedef struct packed {
        logic                  redirect;
        logic                  exception;
        logic [`EX_XLEN-1:0]   target;
        ex_cp0_pkg::exc_code_t code;
    } redirect_t;

endpackage

`default_nettype wire

// ==== design/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_alu (
    input  logic [`EX_XLEN-1:0] instr_i,
    input  ex_isa_pkg::alu_op_t alu_op_i,
    input  logic [`EX_XLEN-1:0] data_a_i,
    input  logic [`EX_XLEN-1:0] data_b_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                overflow_o
);
    import ex_isa_pkg::*;

    logic [`EX_XLEN-1:0] simm;
    logic [`EX_XLEN-1:0] zimm;
    logic [`EX_XLEN-1:0] b_op;
    logic [4:0]          shamt;
    logic [`EX_XLEN:0]   sum;
    logic [`EX_XLEN:0]   diff;

    assign simm  = {{(`EX_XLEN-16){instr_i[15]}}, instr_i[15:0]};
    assign zimm  = {{(`EX_XLEN-16){1'b0}}, instr_i[15:0]};
    assign shamt = instr_i[10:6];

    always_comb begin
        case (alu_op_i)
            ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU: b_op = simm;
            ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI:     b_op = zimm;
            default:                                  b_op = data_b_i;
        endcase
    end

    // One extra sign bit, carry in and out of bit 31 differ on overflow
    assign sum  = {data_a_i[`EX_XLEN-1], data_a_i} + {b_op[`EX_XLEN-1], b_op};
    assign diff = {data_a_i[`EX_XLEN-1], data_a_i} - {data_b_i[`EX_XLEN-1], data_b_i};

    always_comb begin
        case (alu_op_i)
            ALU_ADD, ALU_ADDI:   overflow_o = sum[`EX_XLEN] ^ sum[`EX_XLEN-1];
            ALU_SUB:             overflow_o = diff[`EX_XLEN] ^ diff[`EX_XLEN-1];
            default:             overflow_o = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU: result_o = sum[`EX_XLEN-1:0];
            ALU_SUB, ALU_SUBU:   result_o = diff[`EX_XLEN-1:0];
            ALU_AND, ALU_ANDI:   result_o = data_a_i & b_op;
            ALU_OR, ALU_ORI:     result_o = data_a_i | b_op;
            ALU_XOR, ALU_XORI:   result_o = data_a_i ^ b_op;
            ALU_NOR:             result_o = ~(data_a_i | b_op);
            ALU_SLL:             result_o = data_b_i << shamt;
            ALU_SRL:             result_o = data_b_i >> shamt;
            ALU_SRA:             result_o = $signed(data_b_i) >>> shamt;
            ALU_SLLV:            result_o = data_b_i << data_a_i[4:0];
            ALU_SRLV:            result_o = data_b_i >> data_a_i[4:0];
            ALU_SRAV:            result_o = $signed(data_b_i) >>> data_a_i[4:0];
            ALU_SLT, ALU_SLTI:   result_o = `EX_XLEN'($signed(data_a_i) < $signed(b_op));
            ALU_SLTU, ALU_SLTIU: result_o = `EX_XLEN'(data_a_i < b_op);
            ALU_LUI:             result_o = b_op << 16;
            default:             result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/ex_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_branch_unit (
    input  logic [`EX_XLEN-1:0]      instr_i,
    input  logic [`EX_XLEN-1:0]      data_a_i,
    input  logic [`EX_XLEN-1:0]      data_b_i,
    input  logic [`EX_XLEN-1:0]      npc_i,
    input  ex_isa_pkg::instr_class_t class_i,
    output logic                     taken_o,
    output logic [`EX_XLEN-1:0]      target_o,
    output logic [`EX_XLEN-1:0]      link_o
);
    import ex_isa_pkg::*;

    opcode_t             op;
    logic [`EX_XLEN-1:0] offset;

    assign op     = opcode_t'(instr_i[31:26]);
    assign offset = {{(`EX_XLEN-18){instr_i[15]}}, instr_i[15:0], 2'b00};
    assign link_o = npc_i + `EX_XLEN'd4;

    always_comb begin
        taken_o  = 1'b0;
        target_o = npc_i;
        case (class_i)
            BRANCH: begin
                target_o = npc_i + offset;
                case (op)
                    OP_BEQ:  taken_o = data_a_i == data_b_i;
                    OP_BNE:  taken_o = data_a_i != data_b_i;
                    OP_BLEZ: taken_o = $signed(data_a_i) <= $signed(data_b_i); // a against b
                    OP_BGTZ: taken_o = $signed(data_a_i) > $signed(data_b_i);
                    default: taken_o = 1'b0;
                endcase
            end
            JUMP: begin
                taken_o  = 1'b1;
                target_o = {npc_i[`EX_XLEN-1:28], instr_i[25:0], 2'b00}; // Same 256MB region
            end
            JUMP_REG: begin
                taken_o  = 1'b1;
                target_o = data_a_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/ex_flush_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_flush_counter (
    input  logic clk,
    input  logic rst,
    input  logic load_i,
    input  logic count_i,
    output logic zero_o
);
    localparam int CW = $clog2(`EX_FLUSH_SLOTS + 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= CW'(`EX_FLUSH_SLOTS);
        end else if (count_i) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign zero_o = cnt == '0;

    // Control must stop squashing once the window is used up
    a_no_count_at_zero: assert property (@(posedge clk) disable iff (!rst)
        count_i |-> cnt != '0);

endmodule

`default_nettype wire

// ==== design/ex_cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_cp0_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [5:0]            ip_i,
    input  logic                  exc_enter_i,
    input  ex_cp0_pkg::exc_code_t exc_code_i,
    input  logic                  eret_i,
    input  logic                  mtc0_i,
    input  ex_cp0_pkg::cp0_idx_t  reg_idx_i,
    input  logic [`EX_XLEN-1:0]   wdata_i,
    input  logic [`EX_XLEN-1:0]   npc_i,
    output logic [`EX_XLEN-1:0]   rdata_o,
    output logic [`EX_XLEN-1:0]   vector_o,
    output logic [`EX_XLEN-1:0]   epc_o
);
    import ex_cp0_pkg::*;

    logic [`EX_XLEN-1:0] status, cause, epc, ebase;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            status <= `EX_STATUS_RESET;
            cause  <= '0;
            epc    <= '0;
            ebase  <= `EX_EBASE_RESET;
        end else begin
            cause[CAUSE_IP_HI:CAUSE_IP_LO] <= ip_i; // Interrupt lines mirrored
            if (exc_enter_i) begin
                cause[CAUSE_EXC_HI:CAUSE_EXC_LO] <= exc_code_i;
                if (!status[STATUS_EXL]) begin // Nested exception keeps first EPC
                    status[STATUS_EXL] <= 1'b1;
                    epc <= npc_i - `EX_XLEN'd4;
                end
            end else if (eret_i) begin
                status[STATUS_EXL] <= 1'b0;
            end else if (mtc0_i) begin
                case (reg_idx_i)
                    STATUS:  status <= wdata_i;
                    EPC:     epc <= wdata_i;
                    EBASE:   ebase <= wdata_i;
                    default: ; // Cause is read only
                endcase
            end
        end
    end

    always_comb begin
        case (reg_idx_i)
            STATUS:  rdata_o = status;
            CAUSE:   rdata_o = cause;
            EPC:     rdata_o = epc;
            EBASE:   rdata_o = ebase;
            default: rdata_o = '0;
        endcase
    end

    assign vector_o = ebase + `EX_EXC_OFFSET;
    assign epc_o    = {epc[`EX_XLEN-1:2], 2'b00};

    a_exc_eret_excl: assert property (@(posedge clk) disable iff (!rst)
        !(exc_enter_i && eret_i));

endmodule

`default_nettype wire

// ==== design/ex_out_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_out_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  payload_t d_i,
    output payload_t q_o,
    output logic     valid_o
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            q_o     <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= load_i; // One cycle pulse per accepted instruction
            if (load_i) begin
                q_o <= d_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_control_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_i,
    input  logic [`EX_XLEN-1:0]      instr_i,
    input  logic [`EX_XLEN-1:0]      alu_result_i,
    input  logic                     overflow_i,
    input  logic                     taken_i,
    input  logic [`EX_XLEN-1:0]      target_i,
    input  logic [`EX_XLEN-1:0]      link_i,
    input  logic [`EX_XLEN-1:0]      cp0_rdata_i,
    input  logic [`EX_XLEN-1:0]      vector_i,
    input  logic [`EX_XLEN-1:0]      epc_i,
    input  logic                     zero_i,
    output ex_isa_pkg::alu_op_t      alu_op_o,
    output ex_isa_pkg::instr_class_t class_o,
    output logic                     load_o,
    output logic                     count_o,
    output logic                     exc_enter_o,
    output ex_cp0_pkg::exc_code_t    exc_code_o,
    output logic                     eret_o,
    output logic                     mtc0_o,
    output ex_cp0_pkg::cp0_idx_t     cp0_idx_o,
    output ex_isa_pkg::wb_t          wb_o,
    output ex_isa_pkg::redirect_t    redir_o
);
    import ex_isa_pkg::*;
    import ex_cp0_pkg::*;

    typedef enum logic {RUN, FLUSH} state_t;

    state_t  state;
    opcode_t op;
    funct_t  fn;
    logic    squash;
    logic    live;
    logic    exc;

    assign op        = opcode_t'(instr_i[31:26]);
    assign fn        = funct_t'(instr_i[5:0]);
    assign cp0_idx_o = cp0_idx_t'(instr_i[15:11]);

    always_comb begin
        class_o  = ALU;
        alu_op_o = ALU_ADDU;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    F_ADD:     alu_op_o = ALU_ADD;
                    F_ADDU:    alu_op_o = ALU_ADDU;
                    F_SUB:     alu_op_o = ALU_SUB;
                    F_SUBU:    alu_op_o = ALU_SUBU;
                    F_AND:     alu_op_o = ALU_AND;
                    F_OR:      alu_op_o = ALU_OR;
                    F_XOR:     alu_op_o = ALU_XOR;
                    F_NOR:     alu_op_o = ALU_NOR;
                    F_SLL:     alu_op_o = ALU_SLL;
                    F_SRL:     alu_op_o = ALU_SRL;
                    F_SRA:     alu_op_o = ALU_SRA;
                    F_SLLV:    alu_op_o = ALU_SLLV;
                    F_SRLV:    alu_op_o = ALU_SRLV;
                    F_SRAV:    alu_op_o = ALU_SRAV;
                    F_SLT:     alu_op_o = ALU_SLT;
                    F_SLTU:    alu_op_o = ALU_SLTU;
                    F_JR, F_JALR: class_o = JUMP_REG;
                    F_SYSCALL: class_o = SYSCALL;
                    F_BREAK:   class_o = BREAK;
                    default:   class_o = RESERVED;
                endcase
            end
            OP_ADDI:  alu_op_o = ALU_ADDI;
            OP_ADDIU: alu_op_o = ALU_ADDIU;
            OP_SLTI:  alu_op_o = ALU_SLTI;
            OP_SLTIU: alu_op_o = ALU_SLTIU;
            OP_ANDI:  alu_op_o = ALU_ANDI;
            OP_ORI:   alu_op_o = ALU_ORI;
            OP_XORI:  alu_op_o = ALU_XORI;
            OP_LUI:   alu_op_o = ALU_LUI;
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: class_o = BRANCH;
            OP_J, OP_JAL: class_o = JUMP;
            OP_COP0: begin
                if (instr_i[25] && instr_i[5:0] == ERET_FUNCT)
                    class_o = ERET;
                else if (instr_i[25:21] == RS_MF)
                    class_o = MFC0;
                else if (instr_i[25:21] == RS_MT)
                    class_o = MTC0;
                else
                    class_o = RESERVED;
            end
            default: class_o = RESERVED;
        endcase
    end

    // Squash window ends as soon as the counter has drained
    assign squash = state == FLUSH && !zero_i;
    assign live   = valid_i && !squash;

    always_comb begin
        exc        = 1'b0;
        exc_code_o = exc_code_t'(5'd0);
        wb_o       = '0;
        redir_o    = '0;
        case (class_o)
            ALU: begin
                exc            = overflow_i;
                exc_code_o     = OV;
                wb_o.reg_write = !overflow_i;
                wb_o.result    = alu_result_i;
            end
            BRANCH, JUMP, JUMP_REG: begin
                redir_o.redirect = taken_i;
                redir_o.target   = target_i;
                wb_o.reg_write   = op == OP_JAL || (class_o == JUMP_REG && fn == F_JALR);
                wb_o.result      = link_i;
            end
            MFC0: begin
                wb_o.reg_write = 1'b1;
                wb_o.result    = cp0_rdata_i;
            end
            ERET: begin
                redir_o.redirect = 1'b1;
                redir_o.target   = epc_i;
            end
            SYSCALL: begin
                exc        = 1'b1;
                exc_code_o = SYS;
            end
            BREAK: begin
                exc        = 1'b1;
                exc_code_o = BP;
            end
            RESERVED: begin
                exc        = 1'b1;
                exc_code_o = RI;
            end
            default: ; // MTC0 only touches CP0
        endcase
        if (exc) begin
            redir_o.redirect  = 1'b1;
            redir_o.exception = 1'b1;
            redir_o.target    = vector_i;
            redir_o.code      = exc_code_o;
        end
        if (!live) begin
            wb_o.reg_write    = 1'b0;
            redir_o.redirect  = 1'b0;
            redir_o.exception = 1'b0;
        end
    end

    assign load_o      = redir_o.redirect;
    assign count_o     = valid_i && squash;
    assign exc_enter_o = live && exc;
    assign eret_o      = live && class_o == ERET;
    assign mtc0_o      = live && class_o == MTC0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= RUN;
        end else if (load_o) begin
            state <= FLUSH;
        end else if (state == FLUSH && zero_i) begin
            state <= RUN;
        end
    end

    // Squashed slots issue no redirect and touch no CP0 state
    a_no_redirect_in_flush: assert property (@(posedge clk) disable iff (!rst)
        state == FLUSH && !zero_i |-> !load_o && !exc_enter_o && !eret_o && !mtc0_o);

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`EX_XLEN-1:0]   instr_i,
    input  logic [`EX_XLEN-1:0]   data_a_i,
    input  logic [`EX_XLEN-1:0]   data_b_i,
    input  logic [`EX_XLEN-1:0]   npc_i,
    input  logic                  valid_i,
    input  logic [5:0]            ip_i,
    output logic                  out_valid_o,
    output logic                  reg_write_o,
    output logic [`EX_XLEN-1:0]   result_o,
    output logic                  redirect_o,
    output logic [`EX_XLEN-1:0]   redirect_pc_o,
    output logic                  exception_o,
    output ex_cp0_pkg::exc_code_t exc_code_o
);
    import ex_isa_pkg::*;
    import ex_cp0_pkg::*;

    alu_op_t             alu_op;
    instr_class_t        cls;
    logic [`EX_XLEN-1:0] alu_result, target, link, cp0_rdata, vector, epc;
    logic                overflow, taken;
    logic                load, count, zero;
    logic                exc_enter, eret, mtc0;
    exc_code_t           exc_code;
    cp0_idx_t            cp0_idx;
    wb_t                 wb_d, wb_q;
    redirect_t           redir_d, redir_q;

    ex_alu alu_i (
        .instr_i(instr_i), .alu_op_i(alu_op), .data_a_i(data_a_i), .data_b_i(data_b_i),
        .result_o(alu_result), .overflow_o(overflow)
    );

    ex_branch_unit branch_i (
        .instr_i(instr_i), .data_a_i(data_a_i), .data_b_i(data_b_i), .npc_i(npc_i),
        .class_i(cls), .taken_o(taken), .target_o(target), .link_o(link)
    );

    ex_flush_counter flush_i (
        .clk(clk), .rst(rst), .load_i(load), .count_i(count), .zero_o(zero)
    );

    ex_cp0_regs cp0_i (
        .clk(clk), .rst(rst), .ip_i(ip_i), .exc_enter_i(exc_enter), .exc_code_i(exc_code),
        .eret_i(eret), .mtc0_i(mtc0), .reg_idx_i(cp0_idx), .wdata_i(data_b_i),
        .npc_i(npc_i), .rdata_o(cp0_rdata), .vector_o(vector), .epc_o(epc)
    );

    ex_control_fsm fsm_i (
        .clk(clk), .rst(rst), .valid_i(valid_i), .instr_i(instr_i),
        .alu_result_i(alu_result), .overflow_i(overflow), .taken_i(taken),
        .target_i(target), .link_i(link), .cp0_rdata_i(cp0_rdata), .vector_i(vector),
        .epc_i(epc), .zero_i(zero), .alu_op_o(alu_op), .class_o(cls), .load_o(load),
        .count_o(count), .exc_enter_o(exc_enter), .exc_code_o(exc_code), .eret_o(eret),
        .mtc0_o(mtc0), .cp0_idx_o(cp0_idx), .wb_o(wb_d), .redir_o(redir_d)
    );

    ex_out_reg #(.payload_t(wb_t)) wb_reg (
        .clk(clk), .rst(rst), .load_i(valid_i), .d_i(wb_d), .q_o(wb_q),
        .valid_o(out_valid_o)
    );

    // Valid comes from the write-back copy
    ex_out_reg #(.payload_t(redirect_t)) redir_reg (
        .clk(clk), .rst(rst), .load_i(valid_i), .d_i(redir_d), .q_o(redir_q),
        .valid_o()
    );

    assign reg_write_o   = wb_q.reg_write;
    assign result_o      = wb_q.result;
    assign redirect_o    = redir_q.redirect;
    assign redirect_pc_o = redir_q.target;
    assign exception_o   = redir_q.exception;
    assign exc_code_o    = redir_q.code;

endmodule

`default_nettype wire

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module tb_ex_stage;
    import ex_isa_pkg::*;
    import ex_cp0_pkg::*;

    localparam logic [31:0] VECTOR      = 32'h80001180; // EBase reset plus 0x180
    localparam logic [31:0] FILLER_ADDU = 32'h00000021;
    localparam logic [31:0] ERET_WORD   = 32'h42000018;
    localparam int          WAIT_LIMIT  = 10;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] npc;
        logic        wr;
        logic [31:0] res;
        logic        redir;
        logic [31:0] tgt;
        logic        exc;
        logic [4:0]  code;
    } vec_t;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic [31:0] npc;
    logic        valid;
    logic [5:0]  ip;
    logic        out_valid;
    logic        reg_write;
    logic [31:0] result;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        exception;
    logic [4:0]  exc_code;

    vec_t vecs[$];
    int   errors = 0;
    int   checks = 0;

    ex_stage ex_stage_i (
        .clk(clk), .rst(rst), .instr_i(instr), .data_a_i(data_a), .data_b_i(data_b),
        .npc_i(npc), .valid_i(valid), .ip_i(ip), .out_valid_o(out_valid),
        .reg_write_o(reg_write), .result_o(result), .redirect_o(redirect),
        .redirect_pc_o(redirect_pc), .exception_o(exception), .exc_code_o(exc_code)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [4:0] shamt, input logic [5:0] funct);
        return {6'h00, 15'd0, shamt, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [15:0] imm);
        return {op, 10'd0, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [31:0] enc_cop0(input logic [4:0] rs, input logic [4:0] rd);
        return {6'h10, rs, 5'd0, rd, 11'd0};
    endfunction

    task automatic add_vec(input logic [31:0] ins, a, b, pc, input logic wr,
                           input logic [31:0] res, input logic rd, input logic [31:0] tgt,
                           input logic ex, input logic [4:0] code);
        vec_t v;
        v = '{ins, a, b, pc, wr, res, rd, tgt, ex, code};
        vecs.push_back(v);
    endtask

    task automatic add_commit(input logic [31:0] ins, a, b, res);
        add_vec(ins, a, b, 32'h00400000, 1'b1, res, 1'b0, '0, 1'b0, 5'd0);
    endtask

    task automatic add_silent(input logic [31:0] ins, a, b);
        add_vec(ins, a, b, 32'h00400000, 1'b0, '0, 1'b0, '0, 1'b0, 5'd0);
    endtask

    task automatic add_redirect(input logic [31:0] ins, a, b, pc, input logic wr,
                                input logic [31:0] link, tgt);
        add_vec(ins, a, b, pc, wr, link, 1'b1, tgt, 1'b0, 5'd0);
    endtask

    task automatic add_exception(input logic [31:0] ins, a, b, pc, input logic [4:0] code);
        add_vec(ins, a, b, pc, 1'b0, '0, 1'b1, VECTOR, 1'b1, code);
    endtask

    // Slots after a redirect come out with every flag low
    task automatic add_squash_window(input logic [31:0] ins);
        for (int n = 0; n < `EX_FLUSH_SLOTS; n++) begin
            add_silent(ins, '0, '0);
        end
    endtask

    task automatic build_table();
        add_commit(enc_cop0(RS_MF, STATUS), '0, '0, 32'h0000FA01);
        add_commit(enc_cop0(RS_MF, EBASE), '0, '0, 32'h80001000);
        add_commit(enc_cop0(RS_MF, CAUSE), '0, '0, 32'h0000B400); // ip in 15..10
        // Register and immediate ALU ops
        add_commit(enc_r(5'd0, F_ADDU), 32'hFFFFFFFF, 32'h00000002, 32'h00000001);
        add_commit(enc_r(5'd0, F_ADD), 32'h00001000, 32'h00000234, 32'h00001234);
        add_commit(enc_r(5'd0, F_SUB), 32'h0000000A, 32'h00000003, 32'h00000007);
        add_commit(enc_r(5'd0, F_SUBU), 32'h00000000, 32'h00000001, 32'hFFFFFFFF);
        add_commit(enc_r(5'd0, F_AND), 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000);
        add_commit(enc_r(5'd0, F_OR), 32'hF0F0F0F0, 32'hFF00FF00, 32'hFFF0FFF0);
        add_commit(enc_r(5'd0, F_XOR), 32'hF0F0F0F0, 32'hFF00FF00, 32'h0FF00FF0);
        add_commit(enc_r(5'd0, F_NOR), 32'hF0F0F0F0, 32'h0F0F0000, 32'h00000F0F);
        add_commit(enc_r(5'd4, F_SLL), '0, 32'h12345678, 32'h23456780);
        add_commit(enc_r(5'd8, F_SRL), '0, 32'h80000000, 32'h00800000);
        add_commit(enc_r(5'd8, F_SRA), '0, 32'h80000000, 32'hFF800000);
        add_commit(enc_r(5'd0, F_SLLV), 32'h00000003, 32'h00000011, 32'h00000088);
        add_commit(enc_r(5'd0, F_SRLV), 32'h00000004, 32'hF0000000, 32'h0F000000);
        add_commit(enc_r(5'd0, F_SRAV), 32'h00000004, 32'hF0000000, 32'hFF000000);
        add_commit(enc_r(5'd0, F_SLT), 32'hFFFFFFFF, 32'h00000001, 32'h00000001);
        add_commit(enc_r(5'd0, F_SLTU), 32'hFFFFFFFF, 32'h00000001, 32'h00000000);
        add_commit(enc_i(OP_ADDI, 16'hFFFF), 32'h00000010, '0, 32'h0000000F);
        add_commit(enc_i(OP_ADDIU, 16'h0001), 32'h7FFFFFFF, '0, 32'h80000000);
        add_commit(enc_i(OP_ANDI, 16'h0F0F), 32'h1234FFFF, '0, 32'h00000F0F);
        add_commit(enc_i(OP_ORI, 16'h5678), 32'h12340000, '0, 32'h12345678);
        add_commit(enc_i(OP_XORI, 16'h00F0), 32'h000000FF, '0, 32'h0000000F);
        add_commit(enc_i(OP_SLTI, 16'hFFFF), 32'hFFFFFF00, '0, 32'h00000001);
        add_commit(enc_i(OP_SLTIU, 16'hFFFF), 32'h00000005, '0, 32'h00000001);
        add_commit(enc_i(OP_LUI, 16'hABCD), '0, '0, 32'hABCD0000);
        // Overflow traps, second one nested under EXL
        add_exception(enc_r(5'd0, F_ADD), 32'h7FFFFFFF, 32'h00000001, 32'h00400070, 5'd12);
        add_squash_window(FILLER_ADDU);
        add_commit(enc_cop0(RS_MF, STATUS), '0, '0, 32'h0000FA03);
        add_exception(enc_i(OP_ADDI, 16'hFFFF), 32'h80000000, '0, 32'h00400080, 5'd12);
        add_squash_window(FILLER_ADDU);
        add_commit(enc_cop0(RS_MF, EPC), '0, '0, 32'h0040006C);
        add_redirect(ERET_WORD, '0, '0, 32'h00400090, 1'b0, '0, 32'h0040006C);
        add_squash_window(FILLER_ADDU);
        add_commit(enc_cop0(RS_MF, STATUS), '0, '0, 32'h0000FA01);
        // Branches and jumps
        add_redirect(enc_i(OP_BEQ, 16'h0010), 5, 5, 32'h00400100, 1'b0, '0, 32'h00400140);
        add_squash_window(FILLER_ADDU);
        add_silent(enc_i(OP_BNE, 16'h0010), 5, 5);
        add_commit(enc_i(OP_ORI, 16'h00AA), '0, '0, 32'h000000AA); // No squash after BNE
        add_redirect(enc_i(OP_BNE, 16'hFFFC), 1, 2, 32'h00400200, 1'b0, '0, 32'h004001F0);
        add_squash_window(FILLER_ADDU);
        add_redirect(enc_j(OP_J, 26'h0100040), '0, '0, 32'h30000008, 1'b0, '0,
                     32'h30400100);
        add_squash_window(FILLER_ADDU);
        add_redirect(enc_j(OP_JAL, 26'h0100080), '0, '0, 32'h00400300, 1'b1, 32'h00400304,
                     32'h00400200);
        add_squash_window(FILLER_ADDU);
        add_redirect(enc_r(5'd0, F_JALR), 32'h00401000, '0, 32'h00400400, 1'b1,
                     32'h00400404, 32'h00401000);
        add_squash_window(FILLER_ADDU);
        add_redirect(enc_r(5'd0, F_JR), 32'h00402000, '0, 32'h00400410, 1'b0, '0,
                     32'h00402000);
        add_squash_window(enc_r(5'd0, F_SYSCALL)); // Must leave CP0 alone
        // Trap instructions
        add_exception(enc_r(5'd0, F_SYSCALL), '0, '0, 32'h00400500, 5'd8);
        add_squash_window(FILLER_ADDU);
        add_commit(enc_cop0(RS_MF, EPC), '0, '0, 32'h004004FC);
        add_commit(enc_cop0(RS_MF, STATUS), '0, '0, 32'h0000FA03);
        add_exception(enc_r(5'd0, F_BREAK), '0, '0, 32'h00400600, 5'd9);
        add_squash_window(FILLER_ADDU);
        add_exception(32'hFC000000, '0, '0, 32'h00400700, 5'd10);
        add_squash_window(FILLER_ADDU);
        add_commit(enc_cop0(RS_MF, EPC), '0, '0, 32'h004004FC);
        add_commit(enc_cop0(RS_MF, CAUSE), '0, '0, 32'h0000B428);
        // MTC0 then ERET through the written EPC
        add_silent(enc_cop0(RS_MT, EPC), '0, 32'h00412347);
        add_commit(enc_cop0(RS_MF, EPC), '0, '0, 32'h00412347);
        add_redirect(ERET_WORD, '0, '0, 32'h00400800, 1'b0, '0, 32'h00412344);
        add_squash_window(FILLER_ADDU);
        add_commit(enc_cop0(RS_MF, STATUS), '0, '0, 32'h0000FA01);
    endtask

    task automatic check_field(input string tag, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s %s: got %h expected %h", tag, name, got, exp);
        end
    endtask

    task automatic wait_output(input int idx, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = out_valid;
            cycles++;
        end
        if (!seen) begin
            errors++;
            $display("Timed out waiting for out_valid_o on entry %0d", idx);
        end
    endtask

    initial begin
        string tag;
        logic  seen;
        instr  = '0;
        data_a = '0;
        data_b = '0;
        npc    = '0;
        valid  = 1'b0;
        ip     = 6'h2d;
        rst    = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_field("after reset", "out_valid_o", 32'(out_valid), 32'd0);
        check_field("after reset", "reg_write_o", 32'(reg_write), 32'd0);
        check_field("after reset", "redirect_o", 32'(redirect), 32'd0);
        check_field("after reset", "exception_o", 32'(exception), 32'd0);

        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            instr  <= vecs[i].instr;
            data_a <= vecs[i].a;
            data_b <= vecs[i].b;
            npc    <= vecs[i].npc;
            valid  <= 1'b1;
            @(posedge clk);
            valid  <= 1'b0;
            wait_output(i, seen);
            if (seen) begin
                tag = $sformatf("entry %0d", i);
                check_field(tag, "reg_write_o", 32'(reg_write), 32'(vecs[i].wr));
                check_field(tag, "redirect_o", 32'(redirect), 32'(vecs[i].redir));
                check_field(tag, "exception_o", 32'(exception), 32'(vecs[i].exc));
                if (vecs[i].wr)
                    check_field(tag, "result_o", result, vecs[i].res);
                if (vecs[i].redir)
                    check_field(tag, "redirect_pc_o", redirect_pc, vecs[i].tgt);
                if (vecs[i].exc)
                    check_field(tag, "exc_code_o", 32'(exc_code), 32'(vecs[i].code));
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/ex_cp0_pkg.sv
design/ex_isa_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_flush_counter.sv
design/ex_cp0_regs.sv
design/ex_out_reg.sv
design/ex_control_fsm.sv
design/ex_stage.sv
verif/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_ex_stage
DUT_TOP   ?= ex_stage
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
